// File: Makefile
TOP = ibufTb

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: design/ibufDispatchSelect.sv
// Dispatch side: read addressing, bundle masking, readiness and CSR/exception serialization
`timescale 1ns/1ps
`include "ibuf_settings.svh"

module ibufDispatchSelect
(
	input  logic              clk,
	input  logic              reset,
	input  logic              flush_i,
	input  logic              stall_i,
	input  logic              commitCsr_i,
	ibufDispIf.sel            disp,
	output ibufPkg::ibufPtrT  rdAddr_o [`IBUF_DISPATCH_WIDTH],
	input  ibufPkg::ibufPktT  rdData_i [`IBUF_DISPATCH_WIDTH],
	output logic              ready_o,
	output logic              serialize_o,
	output ibufPkg::ibufPktT  renPacket_o [`IBUF_DISPATCH_WIDTH]
);

	ibufPkg::serializeStateE  state;
	ibufPkg::serializeStateE  stateNext;

	logic [`IBUF_DISPATCH_WIDTH-1:0]  laneMask;
	logic [`IBUF_DISPATCH_WIDTH-1:0]  laneValid;
	// Serializing packet actually leaving this cycle
	logic                             csrOut;
	logic                             excptOut;

	// Full bundle waiting, no back-pressure, not serializing
	assign ready_o = (disp.instCount >= ibufPkg::ibufCountT'(`IBUF_DISPATCH_WIDTH))
		& ~stall_i & (state == ibufPkg::RUN);
	assign serialize_o = state != ibufPkg::RUN;

	always_comb
	begin
		disp.dispatchCount = '0;
		csrOut             = 1'b0;
		excptOut           = 1'b0;
		for (int i = 0; i < `IBUF_DISPATCH_WIDTH; i++)
		begin
			// Consecutive slots from the head
			rdAddr_o[i] = disp.headPtr + ibufPkg::ibufPtrT'(i);
			// Lane 0 always open, later lanes close after a gap or a serializing packet
			if (i == 0)
				laneMask[i] = 1'b1;
			else
				laneMask[i] = laneMask[i-1] & rdData_i[i-1].valid
					& (rdData_i[i-1].instClass != ibufPkg::CSR)
					& ~rdData_i[i-1].exception;
			laneValid[i] = ready_o & laneMask[i] & rdData_i[i].valid;
			// Only valid is squashed, payload passes through
			renPacket_o[i]       = rdData_i[i];
			renPacket_o[i].valid = laneValid[i];
			disp.dispatchCount   = disp.dispatchCount
				+ ibufPkg::ibufDispCountT'(laneValid[i]);
			csrOut   = csrOut | (laneValid[i] & (rdData_i[i].instClass == ibufPkg::CSR));
			excptOut = excptOut | (laneValid[i] & rdData_i[i].exception);
		end
	end

	// Serialize FSM
	always_comb
	begin
		stateNext = state;
		case (state)
			ibufPkg::RUN:
			begin
				// Exception wins over a CSR in the same bundle
				if (excptOut)
					stateNext = ibufPkg::WAIT_EXCPT;
				else if (csrOut)
					stateNext = ibufPkg::WAIT_CSR;
			end
			ibufPkg::WAIT_CSR:
			begin
				if (commitCsr_i)
					stateNext = ibufPkg::RUN;
			end
			ibufPkg::WAIT_EXCPT: stateNext = ibufPkg::WAIT_EXCPT;  // left only by flush
			default: stateNext = ibufPkg::RUN;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= ibufPkg::RUN;
		else if (flush_i)
			state <= ibufPkg::RUN;
		else
			state <= stateNext;
	end

	// After a serializing packet leaves, dispatch is held from the next cycle
	serialHold: assert property (@(posedge clk) disable iff (reset)
		(csrOut || excptOut) && !flush_i |=> serialize_o && (laneValid == '0));

endmodule

// File: design/ibufIfs.sv
// Internal buses of the instruction buffer: RAM write ports and dispatch status
`timescale 1ns/1ps
`include "ibuf_settings.svh"

// Write ports from the queue controller into the RAM
interface ibufWrIf;

	// One set per write port
	logic               wrEn   [`IBUF_WRITE_PORTS];
	ibufPkg::ibufPtrT   wrAddr [`IBUF_WRITE_PORTS];
	ibufPkg::ibufPktT   wrData [`IBUF_WRITE_PORTS];

	// Controller side computes compacted addresses
	modport ctrl (output wrEn, output wrAddr, output wrData);

	// Storage side writes every enabled port at the edge
	modport ram (input wrEn, input wrAddr, input wrData);

endinterface

// Queue state to the dispatch selector and the number dispatched back
interface ibufDispIf;

	ibufPkg::ibufPtrT        headPtr;
	ibufPkg::ibufCountT      instCount;
	// Zero whenever nothing leaves
	ibufPkg::ibufDispCountT  dispatchCount;

	// Controller owns the pointers and occupancy
	modport ctrl (output headPtr, output instCount, input dispatchCount);

	// Selector reports how many lanes went out
	modport sel (input headPtr, input instCount, output dispatchCount);

endinterface

// File: design/ibufPkg.sv
// Shared packet, pointer and state types for the instruction buffer, used by scoped name
`include "ibuf_settings.svh"

package ibufPkg;

	// Coarse opcode class of a decoded packet
	typedef enum logic [2:0]
	{
		ALU    = 3'd0,
		LOAD   = 3'd1,
		STORE  = 3'd2,
		BRANCH = 3'd3,
		CSR    = 3'd4
	} instClassE;

	// Dispatch serialization after CSR or excepting packets
	typedef enum logic [1:0]
	{
		RUN        = 2'd0,
		WAIT_CSR   = 2'd1,
		WAIT_EXCPT = 2'd2
	} serializeStateE;

	// Decoded packet, 29 bits
	typedef struct packed
	{
		logic                         valid;
		instClassE                    instClass;
		logic                         exception;
		logic [`IBUF_TAG_WIDTH-1:0]   tag;
		logic [15:0]                  immediate;
	} ibufPktT;

	// Queue index
	typedef logic [`IBUF_DEPTH_LOG-1:0] ibufPtrT;

	// Occupancy, one bit wider to hold the full depth
	typedef logic [`IBUF_DEPTH_LOG:0] ibufCountT;

	// Packets leaving in one cycle, 0 up to dispatch width
	typedef logic [`IBUF_DISPATCH_LOG:0] ibufDispCountT;

endpackage

// File: design/ibufQueueCtrl.sv
// Circular queue bookkeeping: head, tail, occupancy, write compaction and full flag
`timescale 1ns/1ps
`include "ibuf_settings.svh"

module ibufQueueCtrl
(
	input  logic              clk,
	input  logic              reset,
	input  logic              flush_i,
	input  logic              decodeReady_i,
	input  ibufPkg::ibufPktT  ibPacket_i [`IBUF_WRITE_PORTS],
	output logic              full_o,
	ibufWrIf.ctrl             wr,
	ibufDispIf.ctrl           disp
);

	ibufPkg::ibufPtrT    headPtr;
	ibufPkg::ibufPtrT    tailPtr;
	ibufPkg::ibufCountT  instCount;

	// Accepted this cycle
	logic                accept;
	ibufPkg::ibufCountT  acceptCount;

	// Room must remain for a complete decode bundle
	assign full_o = instCount > ibufPkg::ibufCountT'(`IBUF_DEPTH - `IBUF_WRITE_PORTS);
	assign accept = decodeReady_i & ~full_o;

	// Status toward the selector
	assign disp.headPtr   = headPtr;
	assign disp.instCount = instCount;

	// Compact valid packets onto consecutive slots from the tail
	always_comb
	begin
		ibufPkg::ibufPtrT offset;
		offset      = '0;
		acceptCount = '0;
		for (int i = 0; i < `IBUF_WRITE_PORTS; i++)
		begin
			wr.wrAddr[i] = tailPtr + offset;
			wr.wrData[i] = ibPacket_i[i];
			wr.wrEn[i]   = accept & ibPacket_i[i].valid;
			// Holes in the bundle do not use a slot
			offset       = offset + ibufPkg::ibufPtrT'(ibPacket_i[i].valid);
			acceptCount  = acceptCount + ibufPkg::ibufCountT'(wr.wrEn[i]);
		end
	end

	// Pointer and count registers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			headPtr   <= '0;
			tailPtr   <= '0;
			instCount <= '0;
		end
		else if (flush_i)
		begin
			// Flush drops everything, including this cycle's writes
			headPtr   <= '0;
			tailPtr   <= '0;
			instCount <= '0;
		end
		else
		begin
			// Wrap is free with a power-of-two depth
			tailPtr   <= tailPtr + acceptCount[`IBUF_DEPTH_LOG-1:0];
			headPtr   <= headPtr + ibufPkg::ibufPtrT'(disp.dispatchCount);
			instCount <= instCount + acceptCount
				- ibufPkg::ibufCountT'(disp.dispatchCount);
		end
	end

	// Occupancy never overflows the storage
	countBound: assert property (@(posedge clk) disable iff (reset)
		instCount <= ibufPkg::ibufCountT'(`IBUF_DEPTH));

	// Selector never takes more than is waiting
	dispatchBound: assert property (@(posedge clk) disable iff (reset)
		ibufPkg::ibufCountT'(disp.dispatchCount) <= instCount);

endmodule

// File: design/ibufRam.sv
// Packet storage for the instruction buffer, multi-write at the edge, multi-read combinational
`timescale 1ns/1ps
`include "ibuf_settings.svh"

module ibufRam
(
	input  logic              clk,
	input  logic              reset,
	ibufWrIf.ram              wr,
	input  ibufPkg::ibufPtrT  rdAddr_i [`IBUF_DISPATCH_WIDTH],
	output ibufPkg::ibufPktT  rdData_o [`IBUF_DISPATCH_WIDTH]
);

	ibufPkg::ibufPktT  mem [`IBUF_DEPTH];

	// Cleared on reset so reads never return X
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int e = 0; e < `IBUF_DEPTH; e++)
				mem[e] <= '0;
		end
		else
		begin
			// Addresses differ per port, order does not matter
			for (int p = 0; p < `IBUF_WRITE_PORTS; p++)
			begin
				if (wr.wrEn[p])
					mem[wr.wrAddr[p]] <= wr.wrData[p];
			end
		end
	end

	// Zero-latency read ports
	always_comb
	begin
		for (int r = 0; r < `IBUF_DISPATCH_WIDTH; r++)
			rdData_o[r] = mem[rdAddr_i[r]];
	end

	// Compaction in the controller must never alias two ports
	for (genvar a = 0; a < `IBUF_WRITE_PORTS; a++)
	begin : wrPortA
		for (genvar b = a + 1; b < `IBUF_WRITE_PORTS; b++)
		begin : wrPortB
			wrAddrUnique: assert property (@(posedge clk) disable iff (reset)
				!(wr.wrEn[a] && wr.wrEn[b] && (wr.wrAddr[a] == wr.wrAddr[b])));
		end
	end

endmodule

// File: design/ibufTop.sv
// Instruction buffer top between decode and dispatch, joins controller, RAM and selector
`timescale 1ns/1ps
`include "ibuf_settings.svh"

module ibufTop
(
	input  logic              clk,
	input  logic              reset,
	input  logic              flush_i,
	input  logic              stall_i,
	input  logic              commitCsr_i,
	input  logic              decodeReady_i,
	input  ibufPkg::ibufPktT  ibPacket_i [`IBUF_WRITE_PORTS],
	output logic              full_o,
	output logic              ready_o,
	output logic              serialize_o,
	output ibufPkg::ibufPktT  renPacket_o [`IBUF_DISPATCH_WIDTH]
);

	// Internal buses
	ibufWrIf    wrBus ();
	ibufDispIf  dispBus ();

	// Read path between selector and RAM
	ibufPkg::ibufPtrT  rdAddr [`IBUF_DISPATCH_WIDTH];
	ibufPkg::ibufPktT  rdData [`IBUF_DISPATCH_WIDTH];

	ibufQueueCtrl queueCtrl
	(
		.clk           (clk),
		.reset         (reset),
		.flush_i       (flush_i),
		.decodeReady_i (decodeReady_i),
		.ibPacket_i    (ibPacket_i),
		.full_o        (full_o),
		.wr            (wrBus.ctrl),
		.disp          (dispBus.ctrl)
	);

	ibufRam ram
	(
		.clk      (clk),
		.reset    (reset),
		.wr       (wrBus.ram),
		.rdAddr_i (rdAddr),
		.rdData_o (rdData)
	);

	ibufDispatchSelect dispatchSelect
	(
		.clk         (clk),
		.reset       (reset),
		.flush_i     (flush_i),
		.stall_i     (stall_i),
		.commitCsr_i (commitCsr_i),
		.disp        (dispBus.sel),
		.rdAddr_o    (rdAddr),
		.rdData_i    (rdData),
		.ready_o     (ready_o),
		.serialize_o (serialize_o),
		.renPacket_o (renPacket_o)
	);

endmodule

// File: design/ibuf_settings.svh
// Instruction buffer sizing macros, included by the package, interfaces, RTL and testbench
`ifndef IBUF_SETTINGS_SVH
`define IBUF_SETTINGS_SVH

// Queue storage, power of two so pointers wrap on their own
`define IBUF_DEPTH          16
`define IBUF_DEPTH_LOG      4

// Decode side, two packets per fetch lane because of fission
`define IBUF_FETCH_WIDTH    2
`define IBUF_WRITE_PORTS    (2*`IBUF_FETCH_WIDTH)

// Dispatch side
`define IBUF_DISPATCH_WIDTH 4
`define IBUF_DISPATCH_LOG   2

// Program-order tag carried in each packet
`define IBUF_TAG_WIDTH      8

`endif

// File: tests/ibufTb.sv
// Self-checking instruction buffer testbench, replays the pattern stream against a queue model
`timescale 1ns/1ps
`include "ibuf_settings.svh"

module ibufTb;

	localparam int NUM_PATTERNS   = 24;
	localparam int TIMEOUT_CYCLES = 40 * NUM_PATTERNS;

	logic              clk;
	logic              reset;
	logic              flush;
	logic              stall;
	logic              commitCsr;
	logic              decodeReady;
	ibufPkg::ibufPktT  ibPacket [`IBUF_WRITE_PORTS];
	logic              full;
	logic              ready;
	logic              serialize;
	ibufPkg::ibufPktT  renPacket [`IBUF_DISPATCH_WIDTH];

	// Three words per packet, tag then class then exception
	logic [7:0]   patMem [NUM_PATTERNS*3];
	logic [31:0]  lfsr = 32'haa67;

	// Reference queue in program order
	ibufPkg::ibufPktT         modelQ [$];
	ibufPkg::serializeStateE  modelState;

	// Driver state
	int    patIdx;
	int    offerSize;
	int    offerStart;
	logic  offerPending;
	int    commitDelay;
	int    flushDelay;
	int    cycleCount;

	ibufTop dut
	(
		.clk           (clk),
		.reset         (reset),
		.flush_i       (flush),
		.stall_i       (stall),
		.commitCsr_i   (commitCsr),
		.decodeReady_i (decodeReady),
		.ibPacket_i    (ibPacket),
		.full_o        (full),
		.ready_o       (ready),
		.serialize_o   (serialize),
		.renPacket_o   (renPacket)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsrBit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// Packet for one pattern line, immediate derived from the tag
	function automatic ibufPkg::ibufPktT makePacket(input int idx);
		ibufPkg::ibufPktT pkt;
		pkt.valid     = 1'b1;
		pkt.tag       = patMem[3*idx];
		pkt.instClass = ibufPkg::instClassE'(patMem[3*idx+1][2:0]);
		pkt.exception = patMem[3*idx+2][0];
		pkt.immediate = {pkt.tag, ~pkt.tag};
		return pkt;
	endfunction

	task automatic reportMismatch(input string msg);
		$display("ERROR %0t ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "DUT disagrees with the reference model");
	endtask

	task automatic comparePacket(input ibufPkg::ibufPktT got, input ibufPkg::ibufPktT exp,
		input int lane);
		if (got !== exp)
			reportMismatch($sformatf("lane %0d packet %h, expected %h", lane, got, exp));
	endtask

	task automatic compareCount(input ibufPkg::ibufDispCountT got,
		input ibufPkg::ibufDispCountT exp);
		if (got !== exp)
			reportMismatch($sformatf("dispatched %0d lanes, expected %0d", got, exp));
	endtask

	task automatic compareFlag(input logic got, input logic exp, input string name);
		if (got !== exp)
			reportMismatch($sformatf("%s is %b, expected %b", name, got, exp));
	endtask

	// Lanes up to and including the first CSR or excepting packet
	function automatic int bundleLength();
		int    n;
		logic  closed;
		n      = 0;
		closed = 1'b0;
		for (int i = 0; i < `IBUF_DISPATCH_WIDTH; i++)
		begin
			if (!closed)
			begin
				n      = i + 1;
				closed = (modelQ[i].instClass == ibufPkg::CSR) || modelQ[i].exception;
			end
		end
		return n;
	endfunction

	task automatic checkResetOutputs();
		compareFlag(ready, 1'b0, "ready_o in reset");
		compareFlag(full, 1'b0, "full_o in reset");
		compareFlag(serialize, 1'b0, "serialize_o in reset");
		for (int i = 0; i < `IBUF_DISPATCH_WIDTH; i++)
			compareFlag(renPacket[i].valid, 1'b0, "lane valid in reset");
	endtask

	// Hold the bundle until accepted, pick a new one otherwise
	task automatic driveInputs();
		for (int i = 0; i < `IBUF_WRITE_PORTS; i++)
			ibPacket[i] = '0;
		if (!offerPending && patIdx < NUM_PATTERNS)
		begin
			offerSize = 1 + int'({lfsrBit(), lfsrBit()});
			if (offerSize > NUM_PATTERNS - patIdx)
				offerSize = NUM_PATTERNS - patIdx;
			// Short bundles sometimes start on a later lane
			offerStart = 0;
			if (offerSize < `IBUF_WRITE_PORTS && lfsrBit())
				offerStart = `IBUF_WRITE_PORTS - offerSize;
			offerPending = 1'b1;
		end
		if (offerPending)
		begin
			for (int k = 0; k < offerSize; k++)
				ibPacket[offerStart+k] = makePacket(patIdx + k);
		end
		decodeReady = offerPending;
		stall       = lfsrBit() & lfsrBit();
		commitCsr   = (commitDelay == 1);
		flush       = (flushDelay == 1);
		if (commitDelay > 0)
			commitDelay--;
		if (flushDelay > 0)
			flushDelay--;
	endtask

	// Expected dispatch from the model state before the edge
	task automatic checkOutputs(output int expCount);
		int    gotCount;
		logic  expReady;
		expReady = (modelQ.size() >= `IBUF_DISPATCH_WIDTH) && !stall
			&& (modelState == ibufPkg::RUN);
		expCount = expReady ? bundleLength() : 0;
		gotCount = 0;
		for (int i = 0; i < `IBUF_DISPATCH_WIDTH; i++)
			gotCount += int'(renPacket[i].valid);
		// Bundle size first, then lane by lane
		compareCount(ibufPkg::ibufDispCountT'(gotCount), ibufPkg::ibufDispCountT'(expCount));
		for (int i = 0; i < `IBUF_DISPATCH_WIDTH; i++)
		begin
			if (i < expCount)
				comparePacket(renPacket[i], modelQ[i], i);
			else
				compareFlag(renPacket[i].valid, 1'b0, "masked lane valid");
		end
		compareFlag(ready, expReady, "ready_o");
		compareFlag(full, modelQ.size() > (`IBUF_DEPTH - `IBUF_WRITE_PORTS), "full_o");
		compareFlag(serialize, modelState != ibufPkg::RUN, "serialize_o");
	endtask

	// Apply this cycle's dispatch, write and control to the model
	task automatic advanceModel(input int n);
		ibufPkg::ibufPktT  last;
		logic              accepted;
		accepted = decodeReady && !flush
			&& (modelQ.size() <= (`IBUF_DEPTH - `IBUF_WRITE_PORTS));
		last     = '0;
		if (flush)
		begin
			modelQ.delete();
			modelState = ibufPkg::RUN;
		end
		else
		begin
			for (int k = 0; k < n; k++)
			begin
				last = modelQ.pop_front();
			end
			// Only the last lane of a bundle can serialize
			if (last.exception)
			begin
				modelState = ibufPkg::WAIT_EXCPT;
				flushDelay = 2;
			end
			else if (last.instClass == ibufPkg::CSR)
			begin
				modelState  = ibufPkg::WAIT_CSR;
				commitDelay = 5;
			end
			else if (modelState == ibufPkg::WAIT_CSR && commitCsr)
				modelState = ibufPkg::RUN;
			if (accepted)
			begin
				for (int k = 0; k < offerSize; k++)
					modelQ.push_back(makePacket(patIdx + k));
				patIdx += offerSize;
				offerPending = 1'b0;
			end
		end
	endtask

	// Stream written and nothing left that can still leave
	function automatic logic runFinished();
		return (patIdx == NUM_PATTERNS) && (modelQ.size() < `IBUF_DISPATCH_WIDTH)
			&& (modelState == ibufPkg::RUN) && (commitDelay == 0) && (flushDelay == 0);
	endfunction

	initial
	begin
		int expCount;
		$readmemh("tests/ibuf_patterns.txt", patMem);
		reset        = 1'b1;
		flush        = 1'b0;
		stall        = 1'b0;
		commitCsr    = 1'b0;
		decodeReady  = 1'b0;
		for (int i = 0; i < `IBUF_WRITE_PORTS; i++)
			ibPacket[i] = '0;
		modelState      = ibufPkg::RUN;
		patIdx          = 0;
		offerSize       = 0;
		offerStart      = 0;
		offerPending    = 1'b0;
		commitDelay     = 0;
		flushDelay      = 0;
		cycleCount      = 0;
		repeat (16) @(posedge clk);
		checkResetOutputs();
		#2;
		reset = 1'b0;
		while (!runFinished())
		begin
			driveInputs();
			// Outputs settled half a cycle after the drive
			@(negedge clk);
			checkOutputs(expCount);
			advanceModel(expCount);
			cycleCount++;
			if (cycleCount > TIMEOUT_CYCLES)
			begin
				$display("Test failed");
				$fatal(1, "Timeout, stream not drained after %0d cycles", cycleCount);
			end
			@(posedge clk);
			#2;
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: tests/ibuf_patterns.txt
// Program-order packet stream, one packet per line
// Columns: tag (hex), class (0 ALU 1 LOAD 2 STORE 3 BRANCH 4 CSR), exception bit
01 0 0
02 1 0
03 2 0
04 3 0
05 0 0
06 4 0
07 0 0
08 1 0
09 3 0
0a 0 0
0b 2 0
0c 4 0
0d 1 0
0e 0 1
0f 0 0
10 1 0
11 2 0
12 3 0
13 0 0
14 4 0
15 1 0
16 0 0
17 2 0
18 0 0

// File: verilog.f
+incdir+design
design/ibufPkg.sv
design/ibufIfs.sv
design/ibufQueueCtrl.sv
design/ibufRam.sv
design/ibufDispatchSelect.sv
design/ibufTop.sv
tests/ibufTb.sv
